// ==== hdl/lookup_cfg_pkg.sv ====
/*
 * lookup configuration package
 * default widths and table depth of the exact-match lookup stage,
 * bit positions of the control-stream header fields and the
 * fixed constants used by the loader and the lookup FSM
 */
package lookup_cfg_pkg;

    // data path defaults
    parameter int KEY_W = 32;
    parameter int PHV_W = 64;
    parameter int ACT_W = 64;
    parameter int DEPTH = 16;

    // control stream
    parameter int CTRL_W = 64;

    // header beat layout
    parameter int FLAG_LSB   = 48;
    parameter int FLAG_W     = 16;
    parameter int STAGE_LSB  = 43;
    parameter int STAGE_W    = 5;
    parameter int LOOKUP_LSB = 40;
    parameter int LOOKUP_W   = 3;
    parameter int KIND_LSB   = 36;
    parameter int INDEX_LSB  = 28;

    // marks a header as a lookup table update
    parameter logic [FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

    parameter logic [63:0] DEFAULT_ACTION = 64'h3f;

endpackage

// ==== hdl/lookup_types_pkg.sv ====
/*
 * lookup type package
 * state encodings of the lookup FSM and the table loader FSM,
 * and the entry kind opcode carried in a control header
 */
package lookup_types_pkg;

    typedef enum logic [1:0] {
        lk_idle,
        lk_wait_match,
        lk_wait_action,
        lk_present
    } lookup_state_e;

    typedef enum logic [1:0] {
        ld_idle,
        ld_cam_entry,
        ld_act_entry,
        ld_skip
    } loader_state_e;

    // opcode of a header beat
    typedef enum logic [3:0] {
        kind_cam = 4'd0,
        kind_act = 4'd2
    } entry_kind_e;

endpackage

// ==== hdl/match_cam.sv ====
/*
 * exact-match CAM
 * DEPTH keys with valid bits, compared in parallel against the
 * compare key; the lowest matching index wins and is registered
 * together with the hit flag one cycle after the strobe
 */
`timescale 1ns/1ps

module match_cam #(
    parameter int KEY_W = lookup_cfg_pkg::KEY_W,
    parameter int DEPTH = lookup_cfg_pkg::DEPTH,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [KEY_W-1:0] cmp_key,
    input  logic             cmp_strobe,
    input  logic             we,
    input  logic [IDX_W-1:0] wr_index,
    input  logic [KEY_W-1:0] wr_key,
    output logic             hit,
    output logic [IDX_W-1:0] hit_index
);

    logic [KEY_W-1:0] keys [DEPTH];
    logic [DEPTH-1:0] entry_valid;
    logic             match_any;
    logic [IDX_W-1:0] match_index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (we) begin
            entry_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            keys[wr_index] <= wr_key;
        end
    end

    // priority encoder, scanned from the top so the lowest index wins
    always_comb begin
        match_any   = 1'b0;
        match_index = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && keys[i] == cmp_key) begin
                match_any   = 1'b1;
                match_index = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit       <= 1'b0;
            hit_index <= '0;
        end else if (cmp_strobe) begin
            hit       <= match_any;
            hit_index <= match_index;
        end
    end

    a_wr_index_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(wr_index)
    ) else $error("CAM write with unknown index");

endmodule

// ==== hdl/action_ram.sv ====
/*
 * action table
 * DEPTH x ACT_W storage with one write port and one read port
 * whose data is registered every cycle
 */
`timescale 1ns/1ps

module action_ram #(
    parameter int ACT_W = lookup_cfg_pkg::ACT_W,
    parameter int DEPTH = lookup_cfg_pkg::DEPTH,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             we,
    input  logic [IDX_W-1:0] wr_index,
    input  logic [ACT_W-1:0] wr_data,
    input  logic [IDX_W-1:0] rd_index,
    output logic [ACT_W-1:0] rd_data
);

    logic [ACT_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_index] <= wr_data;
        end
        // old data on a same-address write
        rd_data <= mem[rd_index];
    end

endmodule

// ==== hdl/table_loader.sv ====
/*
 * table loader
 * parses the control stream: a header beat selects the table and the
 * start index, each following beat writes one entry one cycle later
 * and bumps the index. packets for another stage are skipped.
 */
`timescale 1ns/1ps

module table_loader #(
    parameter int KEY_W     = lookup_cfg_pkg::KEY_W,
    parameter int ACT_W     = lookup_cfg_pkg::ACT_W,
    parameter int DEPTH     = lookup_cfg_pkg::DEPTH,
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2,
    localparam int IDX_W    = $clog2(DEPTH)
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [lookup_cfg_pkg::CTRL_W-1:0] ctrl_data,
    input  logic                              ctrl_valid,
    input  logic                              ctrl_last,
    output logic                              cam_we,
    output logic [IDX_W-1:0]                  cam_index,
    output logic [KEY_W-1:0]                  cam_key,
    output logic                              act_we,
    output logic [IDX_W-1:0]                  act_index,
    output logic [ACT_W-1:0]                  act_data
);

    localparam int KIND_W = $bits(lookup_types_pkg::entry_kind_e);

    lookup_types_pkg::loader_state_e state;
    lookup_types_pkg::entry_kind_e   kind;

    logic                              hdr_ok;
    logic [IDX_W-1:0]                  idx;
    logic [IDX_W-1:0]                  wr_idx;
    logic [lookup_cfg_pkg::CTRL_W-1:0] wr_data;

    // header fields
    assign kind = lookup_types_pkg::entry_kind_e'(ctrl_data[lookup_cfg_pkg::KIND_LSB +: KIND_W]);

    assign hdr_ok =
        ctrl_data[lookup_cfg_pkg::FLAG_LSB +: lookup_cfg_pkg::FLAG_W] == lookup_cfg_pkg::CTRL_FLAG
        && ctrl_data[lookup_cfg_pkg::STAGE_LSB +: lookup_cfg_pkg::STAGE_W]
           == lookup_cfg_pkg::STAGE_W'(STAGE_ID)
        && ctrl_data[lookup_cfg_pkg::LOOKUP_LSB +: lookup_cfg_pkg::LOOKUP_W]
           == lookup_cfg_pkg::LOOKUP_W'(LOOKUP_ID);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= lookup_types_pkg::ld_idle;
            idx    <= '0;
            cam_we <= 1'b0;
            act_we <= 1'b0;
        end else begin
            cam_we <= 1'b0;
            act_we <= 1'b0;
            case (state)
                lookup_types_pkg::ld_idle: begin
                    // a single-beat packet carries no entries
                    if (ctrl_valid && !ctrl_last) begin
                        idx <= ctrl_data[lookup_cfg_pkg::INDEX_LSB +: IDX_W];
                        if (!hdr_ok) begin
                            state <= lookup_types_pkg::ld_skip;
                        end else begin
                            case (kind)
                                lookup_types_pkg::kind_cam: state <= lookup_types_pkg::ld_cam_entry;
                                lookup_types_pkg::kind_act: state <= lookup_types_pkg::ld_act_entry;
                                default:                    state <= lookup_types_pkg::ld_skip;
                            endcase
                        end
                    end
                end
                lookup_types_pkg::ld_cam_entry,
                lookup_types_pkg::ld_act_entry: begin
                    if (ctrl_valid) begin
                        cam_we <= (state == lookup_types_pkg::ld_cam_entry);
                        act_we <= (state == lookup_types_pkg::ld_act_entry);
                        idx    <= idx + 1'b1;
                        if (ctrl_last) begin
                            state <= lookup_types_pkg::ld_idle;
                        end
                    end
                end
                lookup_types_pkg::ld_skip: begin
                    if (ctrl_valid && ctrl_last) begin
                        state <= lookup_types_pkg::ld_idle;
                    end
                end
                default: state <= lookup_types_pkg::ld_idle;
            endcase
        end
    end

    // entry beat and its index, written on the next edge
    always_ff @(posedge clk) begin
        if (ctrl_valid && (state == lookup_types_pkg::ld_cam_entry
                           || state == lookup_types_pkg::ld_act_entry)) begin
            wr_idx  <= idx;
            wr_data <= ctrl_data;
        end
    end

    assign cam_index = wr_idx;
    assign act_index = wr_idx;
    assign cam_key   = wr_data[KEY_W-1:0];
    assign act_data  = wr_data[ACT_W-1:0];

    a_one_table: assert property (
        @(posedge clk) disable iff (!rst_n) !(cam_we && act_we)
    ) else $error("CAM and action RAM written in the same cycle");

endmodule

// ==== hdl/lookup_ctrl.sv ====
/*
 * lookup control FSM
 * accepts one key at a time, strobes the CAM with the captured key,
 * picks the default action on a miss or the action RAM word on a hit
 * and holds the result until the downstream stage takes it
 */
`timescale 1ns/1ps

module lookup_ctrl #(
    parameter int KEY_W = lookup_cfg_pkg::KEY_W,
    parameter int PHV_W = lookup_cfg_pkg::PHV_W,
    parameter int ACT_W = lookup_cfg_pkg::ACT_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [KEY_W-1:0] key,
    input  logic [PHV_W-1:0] phv,
    input  logic             key_valid,
    input  logic             ready_in,
    input  logic             hit,
    input  logic [ACT_W-1:0] act_rdata,
    output logic             ready_out,
    output logic [KEY_W-1:0] cmp_key,
    output logic             cmp_strobe,
    output logic [ACT_W-1:0] action,
    output logic [PHV_W-1:0] phv_out,
    output logic             action_valid
);

    lookup_types_pkg::lookup_state_e state;

    logic accept;
    logic miss_done;

    assign accept = (state == lookup_types_pkg::lk_idle) && ready_out && key_valid;

    // the CAM result is ready once the strobe cycle has passed
    assign miss_done = (state == lookup_types_pkg::lk_wait_match) && !cmp_strobe && !hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= lookup_types_pkg::lk_idle;
            ready_out    <= 1'b1;
            cmp_strobe   <= 1'b0;
            action_valid <= 1'b0;
        end else begin
            case (state)
                lookup_types_pkg::lk_idle: begin
                    // one idle cycle after a transfer before taking a new key
                    if (!ready_out) begin
                        ready_out <= 1'b1;
                    end else if (key_valid) begin
                        ready_out  <= 1'b0;
                        cmp_strobe <= 1'b1;
                        state      <= lookup_types_pkg::lk_wait_match;
                    end
                end
                lookup_types_pkg::lk_wait_match: begin
                    cmp_strobe <= 1'b0;
                    if (!cmp_strobe) begin
                        if (hit) begin
                            state <= lookup_types_pkg::lk_wait_action;
                        end else begin
                            action_valid <= 1'b1;
                            state        <= lookup_types_pkg::lk_present;
                        end
                    end
                end
                lookup_types_pkg::lk_wait_action: begin
                    // RAM word for hit_index is out now
                    action_valid <= 1'b1;
                    state        <= lookup_types_pkg::lk_present;
                end
                lookup_types_pkg::lk_present: begin
                    if (ready_in) begin
                        action_valid <= 1'b0;
                        state        <= lookup_types_pkg::lk_idle;
                    end
                end
                default: state <= lookup_types_pkg::lk_idle;
            endcase
        end
    end

    // captured key, phv and selected action
    always_ff @(posedge clk) begin
        if (accept) begin
            cmp_key <= key;
            phv_out <= phv;
        end
        if (miss_done) begin
            action <= ACT_W'(lookup_cfg_pkg::DEFAULT_ACTION);
        end else if (state == lookup_types_pkg::lk_wait_action) begin
            action <= act_rdata;
        end
    end

    // result must not move while downstream stalls
    property p_hold_result;
        @(posedge clk) disable iff (!rst_n)
        action_valid && !ready_in |=> $stable(action) && $stable(phv_out);
    endproperty

    a_hold_result: assert property (p_hold_result)
        else $error("result changed under back-pressure");

endmodule

// ==== hdl/lookup_engine.sv ====
/*
 * exact-match lookup engine
 * takes a key with its phv, finds the lowest matching CAM entry and
 * returns the action for it, or the default action on a miss.
 * a control stream loads the CAM and action tables.
 */
`timescale 1ns/1ps

module lookup_engine #(
    parameter int KEY_W     = lookup_cfg_pkg::KEY_W,
    parameter int PHV_W     = lookup_cfg_pkg::PHV_W,
    parameter int ACT_W     = lookup_cfg_pkg::ACT_W,
    parameter int DEPTH     = lookup_cfg_pkg::DEPTH,
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [KEY_W-1:0]                  key,
    input  logic [PHV_W-1:0]                  phv,
    input  logic                              key_valid,
    output logic                              ready_out,
    output logic [ACT_W-1:0]                  action,
    output logic [PHV_W-1:0]                  phv_out,
    output logic                              action_valid,
    input  logic                              ready_in,
    input  logic [lookup_cfg_pkg::CTRL_W-1:0] ctrl_data,
    input  logic                              ctrl_valid,
    input  logic                              ctrl_last
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [KEY_W-1:0] cmp_key;
    logic             cmp_strobe;
    logic             hit;
    logic [IDX_W-1:0] hit_index;
    logic [ACT_W-1:0] act_rdata;

    // table write side
    logic             cam_we;
    logic [IDX_W-1:0] cam_index;
    logic [KEY_W-1:0] cam_key;
    logic             act_we;
    logic [IDX_W-1:0] act_index;
    logic [ACT_W-1:0] act_data;

    lookup_ctrl #(
        .KEY_W (KEY_W),
        .PHV_W (PHV_W),
        .ACT_W (ACT_W)
    ) i_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .phv          (phv),
        .key_valid    (key_valid),
        .ready_in     (ready_in),
        .hit          (hit),
        .act_rdata    (act_rdata),
        .ready_out    (ready_out),
        .cmp_key      (cmp_key),
        .cmp_strobe   (cmp_strobe),
        .action       (action),
        .phv_out      (phv_out),
        .action_valid (action_valid)
    );

    match_cam #(
        .KEY_W (KEY_W),
        .DEPTH (DEPTH)
    ) i_match_cam (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmp_key    (cmp_key),
        .cmp_strobe (cmp_strobe),
        .we         (cam_we),
        .wr_index   (cam_index),
        .wr_key     (cam_key),
        .hit        (hit),
        .hit_index  (hit_index)
    );

    action_ram #(
        .ACT_W (ACT_W),
        .DEPTH (DEPTH)
    ) i_action_ram (
        .clk      (clk),
        .we       (act_we),
        .wr_index (act_index),
        .wr_data  (act_data),
        .rd_index (hit_index),
        .rd_data  (act_rdata)
    );

    table_loader #(
        .KEY_W     (KEY_W),
        .ACT_W     (ACT_W),
        .DEPTH     (DEPTH),
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) i_table_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_data  (ctrl_data),
        .ctrl_valid (ctrl_valid),
        .ctrl_last  (ctrl_last),
        .cam_we     (cam_we),
        .cam_index  (cam_index),
        .cam_key    (cam_key),
        .act_we     (act_we),
        .act_index  (act_index),
        .act_data   (act_data)
    );

endmodule

// ==== test/lookup_tb_util.svh ====
/*
 * lookup testbench helpers
 * galois LFSR for random stimulus, control header packing and
 * single-beat driving of the control stream
 */

logic [31:0] lfsr_state = 32'hbe15cb48;

// galois step, feedback taps 0x80200003
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[62:0], lfsr_state[0]};
    end
    return v;
endfunction

// flag, stage id, lookup id, kind, start index, unused low bits
function automatic logic [63:0] make_header(input logic [15:0] flag, input logic [4:0] stage,
                                            input logic [3:0] kind, input logic [7:0] index);
    return {flag, stage, 3'(LOOKUP_ID), kind, index, 28'h0};
endfunction

task automatic ctrl_beat(input logic [63:0] data, input logic last);
    @(negedge clk);
    ctrl_data  = data;
    ctrl_valid = 1'b1;
    ctrl_last  = last;
endtask

// ==== test/lookup_tb.sv ====
/*
 * lookup engine testbench
 * loads the CAM and action tables over the control stream, runs
 * lookups against a model of the tables and checks latency, result
 * values and back-pressure behavior with concurrent assertions
 */
`timescale 1ns/1ps

module lookup_tb;

    localparam int KEY_W     = lookup_cfg_pkg::KEY_W;
    localparam int PHV_W     = lookup_cfg_pkg::PHV_W;
    localparam int ACT_W     = lookup_cfg_pkg::ACT_W;
    localparam int DEPTH     = lookup_cfg_pkg::DEPTH;
    localparam int STAGE_ID  = 0;
    localparam int LOOKUP_ID = 2;
    // all tests together run for roughly 200 to 500 cycles
    localparam int MAX_CYCLES = 2000;

    logic             clk;
    logic             rst_n;
    logic [KEY_W-1:0] key;
    logic [PHV_W-1:0] phv;
    logic             key_valid;
    logic             ready_out;
    logic [ACT_W-1:0] action;
    logic [PHV_W-1:0] phv_out;
    logic             action_valid;
    logic             ready_in;
    logic [63:0]      ctrl_data;
    logic             ctrl_valid;
    logic             ctrl_last;

    // table model and expected result
    logic [KEY_W-1:0] ref_key [DEPTH];
    logic [DEPTH-1:0] ref_valid;
    logic [ACT_W-1:0] ref_act [DEPTH];
    logic             exp_hit;
    logic [ACT_W-1:0] exp_action;
    logic [PHV_W-1:0] exp_phv;
    logic [KEY_W-1:0] keys [4];
    logic [KEY_W-1:0] dup_key;
    logic [63:0]      entries [$];
    int               fail_count = 0;
    int               test_fails = 0;
    int               test_count = 0;
    int               cycle      = 0;

    `include "lookup_tb_util.svh"

    lookup_engine i_lookup_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .phv          (phv),
        .key_valid    (key_valid),
        .ready_out    (ready_out),
        .action       (action),
        .phv_out      (phv_out),
        .action_valid (action_valid),
        .ready_in     (ready_in),
        .ctrl_data    (ctrl_data),
        .ctrl_valid   (ctrl_valid),
        .ctrl_last    (ctrl_last)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    wire accept   = key_valid && ready_out;
    wire transfer = action_valid && ready_in;

    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> ready_out && !action_valid)
    else begin
        fail_count++;
        $display("after reset ready_out was not high or action_valid was not low");
    end

    a_miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !exp_hit |=> !action_valid ##1 !action_valid ##1 action_valid)
    else begin
        fail_count++;
        $display("action_valid did not rise two cycles after a missed key was accepted");
    end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept && exp_hit |=> !action_valid ##1 !action_valid ##1 !action_valid ##1 action_valid)
    else begin
        fail_count++;
        $display("action_valid did not rise three cycles after a hit key was accepted");
    end

    a_action_value: assert property (@(posedge clk) disable iff (!rst_n)
        transfer |-> action == exp_action)
    else begin
        fail_count++;
        $display("[FAIL] action: got %h, expected %h", $sampled(action), exp_action);
    end

    a_phv_value: assert property (@(posedge clk) disable iff (!rst_n)
        transfer |-> phv_out == exp_phv)
    else begin
        fail_count++;
        $display("[FAIL] phv_out: got %h, expected %h", $sampled(phv_out), exp_phv);
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        action_valid && !ready_in |=> action_valid && $stable(action) && $stable(phv_out))
    else begin
        fail_count++;
        $display("result was dropped or changed while ready_in was low");
    end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n) action_valid |-> !ready_out)
    else begin
        fail_count++;
        $display("ready_out was high while a result was pending");
    end

    a_release: assert property (@(posedge clk) disable iff (!rst_n)
        transfer |=> !action_valid ##1 ready_out)
    else begin
        fail_count++;
        $display("ready_out did not return high on the edge after the transfer");
    end

    task automatic random_entries(input int n, input int width);
        entries.delete();
        repeat (n) entries.push_back(take_bits(width));
    endtask

    // sends header plus entries and mirrors the writes into the model
    task automatic send_packet(input logic [63:0] hdr);
        int   idx;
        logic for_us;
        for_us = hdr[63:48] == lookup_cfg_pkg::CTRL_FLAG && hdr[47:43] == 5'(STAGE_ID)
                 && hdr[42:40] == 3'(LOOKUP_ID);
        idx = int'(hdr[35:28]) % DEPTH;
        ctrl_beat(hdr, 1'b0);
        foreach (entries[i]) begin
            ctrl_beat(entries[i], i == entries.size() - 1);
            if (for_us && hdr[39:36] == 4'(lookup_types_pkg::kind_cam)) begin
                ref_key[idx]   = KEY_W'(entries[i]);
                ref_valid[idx] = 1'b1;
            end else if (for_us && hdr[39:36] == 4'(lookup_types_pkg::kind_act)) begin
                ref_act[idx] = ACT_W'(entries[i]);
            end
            idx = (idx + 1) % DEPTH;
        end
        @(negedge clk);
        ctrl_valid = 1'b0;
        ctrl_last  = 1'b0;
    endtask

    task automatic do_lookup(input logic [KEY_W-1:0] k, input logic [PHV_W-1:0] p,
                             input int hold);
        @(negedge clk);
        // lowest valid index with an equal key wins
        exp_hit    = 1'b0;
        exp_action = ACT_W'(lookup_cfg_pkg::DEFAULT_ACTION);
        for (int i = 0; i < DEPTH; i++) begin
            if (!exp_hit && ref_valid[i] && ref_key[i] == k) begin
                exp_hit    = 1'b1;
                exp_action = ref_act[i];
            end
        end
        exp_phv   = p;
        key       = k;
        phv       = p;
        key_valid = 1'b1;
        ready_in  = (hold == 0);
        while (!ready_out) begin
            @(negedge clk);
        end
        @(negedge clk);
        key_valid = 1'b0;
        while (!action_valid) begin
            @(negedge clk);
        end
        repeat (hold) @(negedge clk);
        ready_in = 1'b1;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        repeat (3) @(negedge clk);
        test_count++;
        $display("test %0d %s: %0d check failures", test_count, name, fail_count - test_fails);
        test_fails = fail_count;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        key        = '0;
        phv        = '0;
        key_valid  = 1'b0;
        ready_in   = 1'b1;
        ctrl_data  = '0;
        ctrl_valid = 1'b0;
        ctrl_last  = 1'b0;
        ref_valid  = '0;
        exp_hit    = 1'b0;
        exp_action = '0;
        exp_phv    = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        repeat (2) do_lookup(KEY_W'(take_bits(KEY_W)), PHV_W'(take_bits(PHV_W)), 0);
        end_test("empty table miss");

        random_entries(4, KEY_W);
        foreach (keys[i]) keys[i] = KEY_W'(entries[i]);
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG, 5'(STAGE_ID), 4'd0, 8'd0));
        random_entries(4, ACT_W);
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG, 5'(STAGE_ID), 4'd2, 8'd0));
        foreach (keys[i]) do_lookup(keys[i], PHV_W'(take_bits(PHV_W)), 0);
        end_test("loaded table hits");

        // same key at 5 and 9, actions over 5..9
        random_entries(1, KEY_W);
        dup_key = KEY_W'(entries[0]);
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG, 5'(STAGE_ID), 4'd0, 8'd5));
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG, 5'(STAGE_ID), 4'd0, 8'd9));
        random_entries(5, ACT_W);
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG, 5'(STAGE_ID), 4'd2, 8'd5));
        do_lookup(dup_key, PHV_W'(take_bits(PHV_W)), 0);
        end_test("lowest index priority");

        random_entries(4, ACT_W);
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG, 5'(STAGE_ID + 1), 4'd2, 8'd0));
        send_packet(make_header(lookup_cfg_pkg::CTRL_FLAG ^ 16'h0100, 5'(STAGE_ID), 4'd2, 8'd0));
        foreach (keys[i]) do_lookup(keys[i], PHV_W'(take_bits(PHV_W)), 0);
        end_test("foreign packets skipped");

        repeat (2) do_lookup(keys[2], PHV_W'(take_bits(PHV_W)), 1 + int'(take_bits(4)));
        do_lookup(KEY_W'(take_bits(KEY_W)), PHV_W'(take_bits(PHV_W)), 1 + int'(take_bits(4)));
        end_test("back-pressure hold");

        $display("%0d tests run, %0d check failures in total", test_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/lookup_cfg_pkg.sv
hdl/lookup_types_pkg.sv
hdl/match_cam.sv
hdl/action_ram.sv
hdl/table_loader.sv
hdl/lookup_ctrl.sv
hdl/lookup_engine.sv
+incdir+test
test/lookup_tb.sv
